// ==== include/predictor_settings.svh ====
`ifndef PREDICTOR_SETTINGS_SVH
`define PREDICTOR_SETTINGS_SVH

// Table geometry for 32 entries per table
`define BTB_INDEX_BITS 5
`define BTB_ADDR_BITS 14

// Resolution queue and producer credit counter
`define BTB_QUEUE_DEPTH 4
`define BTB_CREDIT_BITS 3  // Must hold 0 to BTB_QUEUE_DEPTH

`endif

// ==== hdl/btbPkg.sv ====
package btbPkg;

`include "predictor_settings.svh"

  localparam int tagBits = `BTB_ADDR_BITS - `BTB_INDEX_BITS;

  // 2-bit saturating counter
  typedef enum logic [1:0] {
    strongNot   = 2'd0,
    weakNot     = 2'd1,
    weakTaken   = 2'd2,
    strongTaken = 2'd3
  } counterT;

  typedef struct packed {
    logic [tagBits-1:0]        tag;
    logic                      valid;
    logic [`BTB_ADDR_BITS-1:0] target;
    counterT                   counter;
  } branchEntryT;

  // Return view without a stored target
  typedef struct packed {
    logic [tagBits-1:0]        tag;
    logic                      valid;
    logic [`BTB_ADDR_BITS-1:0] unused;
    counterT                   counter;
  } returnEntryT;

  typedef union packed {
    branchEntryT branch;
    returnEntryT ret;
  } btbEntryT;

  typedef struct packed {
    logic [`BTB_ADDR_BITS-1:0] addr;
    logic                      isReturn;
    logic                      taken;
    logic [`BTB_ADDR_BITS-1:0] target;
  } resolveT;

endpackage

// ==== hdl/btbUpdateIf.sv ====
`timescale 1ns/100ps
`include "predictor_settings.svh"

interface btbUpdateIf;
  import btbPkg::*;

  logic branchWe;
  logic returnWe;
  logic [`BTB_INDEX_BITS-1:0] wrIndex;
  btbEntryT wrEntry;
  logic [`BTB_INDEX_BITS-1:0] rdIndex;  // Index of the queue head
  btbEntryT branchRdEntry;
  btbEntryT returnRdEntry;

  modport resolver (
    output branchWe, returnWe, wrIndex, wrEntry, rdIndex,
    input  branchRdEntry, returnRdEntry
  );

  // Table side answers the read combinationally
  modport tables (
    input  branchWe, returnWe, wrIndex, wrEntry, rdIndex,
    output branchRdEntry, returnRdEntry
  );

endinterface

// ==== hdl/btbUpdateQueue.sv ====
`timescale 1ns/100ps
`include "predictor_settings.svh"

module btbUpdateQueue (
  input  logic            BTBCLK,
  input  logic            rstN,
  input  logic            pushValid,
  input  btbPkg::resolveT pushRecord,
  output logic            headValid,
  output btbPkg::resolveT head,
  input  logic            pop,
  output logic            credit
);
  import btbPkg::*;

  localparam int ptrBits = $clog2(`BTB_QUEUE_DEPTH);
  localparam int cntBits = `BTB_CREDIT_BITS;

  resolveT mem [`BTB_QUEUE_DEPTH];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [cntBits-1:0] count;
  logic popDone;  // Pop taken at the last edge

  function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
    nextPtr = (ptr == ptrBits'(`BTB_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge BTBCLK or negedge rstN) begin
    if (!rstN) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      popDone <= 1'b0;
      credit  <= 1'b0;
    end else begin
      if (pushValid) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      count   <= count + cntBits'(pushValid) - cntBits'(pop);
      popDone <= pop;
      credit  <= popDone;  // Returned one cycle after the pop
    end
  end

  always_ff @(posedge BTBCLK) begin
    if (pushValid) mem[wrPtr] <= pushRecord;
  end

  assign headValid = (count != '0);
  assign head      = mem[rdPtr];

  // Producer must hold a credit
  pushNotFull: assert property (@(posedge BTBCLK) disable iff (!rstN)
    pushValid |-> (count != cntBits'(`BTB_QUEUE_DEPTH)));

  popNotEmpty: assert property (@(posedge BTBCLK) disable iff (!rstN)
    pop |-> (count != '0));

endmodule

// ==== hdl/btbResolve.sv ====
`timescale 1ns/100ps
`include "predictor_settings.svh"

module btbResolve (
  input  logic            headValid,
  input  btbPkg::resolveT head,
  output logic            pop,
  btbUpdateIf.resolver    upd
);
  import btbPkg::*;

  logic [`BTB_INDEX_BITS-1:0] index;
  logic [tagBits-1:0] tag;
  branchEntryT branchOld;
  returnEntryT returnOld;
  logic branchHit;
  logic returnHit;
  btbEntryT newEntry;

  function automatic counterT stepCounter(input counterT cnt, input logic taken);
    case (cnt)
      strongNot:   stepCounter = taken ? weakNot : strongNot;
      weakNot:     stepCounter = taken ? weakTaken : strongNot;
      weakTaken:   stepCounter = taken ? strongTaken : weakNot;
      default:     stepCounter = taken ? strongTaken : weakTaken;
    endcase
  endfunction

  assign index = head.addr[`BTB_INDEX_BITS-1:0];
  assign tag   = head.addr[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];

  assign upd.rdIndex = index;
  assign upd.wrIndex = index;
  assign pop         = headValid;  // Drain one record per cycle

  assign branchOld = upd.branchRdEntry.branch;
  assign returnOld = upd.returnRdEntry.ret;
  assign branchHit = branchOld.valid && (branchOld.tag == tag);
  assign returnHit = returnOld.valid && (returnOld.tag == tag);

  always_comb begin
    newEntry     = upd.branchRdEntry;
    upd.branchWe = 1'b0;
    upd.returnWe = 1'b0;
    if (headValid && !head.isReturn) begin
      if (branchHit) begin
        upd.branchWe = 1'b1;
        newEntry.branch.counter = stepCounter(branchOld.counter, head.taken);
        // Mispredicted target
        if (head.taken && (branchOld.target != head.target)) begin
          newEntry.branch.target = head.target;
        end
      end else if (head.taken) begin
        upd.branchWe            = 1'b1;  // Allocate
        newEntry.branch.tag     = tag;
        newEntry.branch.valid   = 1'b1;
        newEntry.branch.target  = head.target;
        newEntry.branch.counter = weakTaken;
      end
    end else if (headValid && (returnHit || head.taken)) begin
      upd.returnWe         = 1'b1;
      newEntry.ret.tag     = tag;
      newEntry.ret.valid   = 1'b1;
      newEntry.ret.unused  = '0;
      newEntry.ret.counter = returnHit ? stepCounter(returnOld.counter, head.taken)
                                       : weakTaken;
    end
  end

  assign upd.wrEntry = newEntry;

endmodule

// ==== hdl/btbLookup.sv ====
`timescale 1ns/100ps
`include "predictor_settings.svh"

module btbLookup (
  input  logic                      BTBCLK,
  input  logic                      rstN,
  input  logic                      fetchValid,
  input  logic [`BTB_ADDR_BITS-1:0] fetchAddr,
  btbUpdateIf.tables                upd,
  output logic                      predValid,
  output logic                      predHit,
  output logic                      predTaken,
  output logic                      predReturn,
  output logic [`BTB_ADDR_BITS-1:0] predTarget
);
  import btbPkg::*;

  localparam int depth = 1 << `BTB_INDEX_BITS;

  btbEntryT branchTable [depth];
  btbEntryT returnTable [depth];
  logic [depth-1:0] branchValid;
  logic [depth-1:0] returnValid;

  logic [`BTB_INDEX_BITS-1:0] fetchIndex;
  logic [tagBits-1:0] fetchTag;
  btbEntryT branchRd;
  btbEntryT returnRd;
  btbEntryT branchFetch;
  btbEntryT returnFetch;
  logic conflict;
  logic branchHit;
  logic returnHit;
  logic branchTaken;
  logic returnTaken;

  // Valid bits are held apart from the entry storage
  always_ff @(posedge BTBCLK) begin
    if (upd.branchWe) branchTable[upd.wrIndex] <= upd.wrEntry;
    if (upd.returnWe) returnTable[upd.wrIndex] <= upd.wrEntry;
  end

  always_ff @(posedge BTBCLK or negedge rstN) begin
    if (!rstN) begin
      branchValid <= '0;
      returnValid <= '0;
    end else begin
      if (upd.branchWe) branchValid[upd.wrIndex] <= upd.wrEntry.branch.valid;
      if (upd.returnWe) returnValid[upd.wrIndex] <= upd.wrEntry.ret.valid;
    end
  end

  // Read port for the resolver
  always_comb begin
    branchRd              = branchTable[upd.rdIndex];
    branchRd.branch.valid = branchValid[upd.rdIndex];
    returnRd              = returnTable[upd.rdIndex];
    returnRd.ret.valid    = returnValid[upd.rdIndex];
  end

  assign upd.branchRdEntry = branchRd;
  assign upd.returnRdEntry = returnRd;

  assign fetchIndex = fetchAddr[`BTB_INDEX_BITS-1:0];
  assign fetchTag   = fetchAddr[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];

  always_comb begin
    branchFetch              = branchTable[fetchIndex];
    branchFetch.branch.valid = branchValid[fetchIndex];
    returnFetch              = returnTable[fetchIndex];
    returnFetch.ret.valid    = returnValid[fetchIndex];
  end

  // A write to the same index this cycle forces a miss
  assign conflict = (upd.branchWe || upd.returnWe) && (upd.wrIndex == fetchIndex);

  assign branchHit = fetchValid && branchFetch.branch.valid
                     && (branchFetch.branch.tag == fetchTag) && !conflict;
  assign returnHit = fetchValid && returnFetch.ret.valid
                     && (returnFetch.ret.tag == fetchTag) && !conflict;

  assign branchTaken = branchHit && (branchFetch.branch.counter != strongNot);
  assign returnTaken = returnHit && (returnFetch.ret.counter != strongNot);

  always_ff @(posedge BTBCLK or negedge rstN) begin
    if (!rstN) begin
      predValid  <= 1'b0;
      predHit    <= 1'b0;
      predTaken  <= 1'b0;
      predReturn <= 1'b0;
    end else begin
      predValid  <= fetchValid;
      predHit    <= branchHit || returnHit;
      predTaken  <= branchTaken || returnTaken;
      predReturn <= returnHit;  // Return wins over branch
    end
  end

  always_ff @(posedge BTBCLK) begin
    predTarget <= branchHit ? branchFetch.branch.target : '0;
  end

endmodule

// ==== hdl/branchPredictor.sv ====
`timescale 1ns/100ps
`include "predictor_settings.svh"

module branchPredictor (
  input  logic                      BTBCLK,
  input  logic                      rstN,
  input  logic                      fetchValid,
  input  logic [`BTB_ADDR_BITS-1:0] fetchAddr,
  input  logic                      resolveValid,
  input  logic [`BTB_ADDR_BITS-1:0] resolveAddr,
  input  logic                      resolveIsReturn,
  input  logic                      resolveTaken,
  input  logic [`BTB_ADDR_BITS-1:0] resolveTarget,
  output logic                      resolveCredit,
  output logic                      predValid,
  output logic                      predHit,
  output logic                      predTaken,
  output logic                      predReturn,
  output logic [`BTB_ADDR_BITS-1:0] predTarget
);
  import btbPkg::*;

  resolveT pushRecord;
  resolveT head;
  logic headValid;
  logic pop;

  btbUpdateIf upd ();

  assign pushRecord = '{addr: resolveAddr, isReturn: resolveIsReturn,
                        taken: resolveTaken, target: resolveTarget};

  btbUpdateQueue queue (
    .BTBCLK     (BTBCLK),
    .rstN       (rstN),
    .pushValid  (resolveValid),
    .pushRecord (pushRecord),
    .headValid  (headValid),
    .head       (head),
    .pop        (pop),
    .credit     (resolveCredit)
  );

  btbResolve resolver (
    .headValid (headValid),
    .head      (head),
    .pop       (pop),
    .upd       (upd.resolver)
  );

  btbLookup lookup (
    .BTBCLK     (BTBCLK),
    .rstN       (rstN),
    .fetchValid (fetchValid),
    .fetchAddr  (fetchAddr),
    .upd        (upd.tables),
    .predValid  (predValid),
    .predHit    (predHit),
    .predTaken  (predTaken),
    .predReturn (predReturn),
    .predTarget (predTarget)
  );

endmodule

// ==== bench/branchPredictorTb.sv ====
`timescale 1ns/100ps
`include "predictor_settings.svh"

module branchPredictorTb;
  import btbPkg::*;

  localparam int clkPeriod = 4;
  localparam int depth = 1 << `BTB_INDEX_BITS;
  localparam int tagW = `BTB_ADDR_BITS - `BTB_INDEX_BITS;
  localparam int randomOps = 300;
  localparam int maxCycles = 300 + randomOps * 8;  // Worst case per op incl. drain

  typedef struct packed {
    logic hit;
    logic taken;
    logic ret;
    logic branchHit;
    logic [`BTB_ADDR_BITS-1:0] target;
  } expectT;

  logic BTBCLK, rstN, fetchValid, resolveValid, resolveIsReturn, resolveTaken;
  logic [`BTB_ADDR_BITS-1:0] fetchAddr, resolveAddr, resolveTarget, predTarget;
  logic resolveCredit, predValid, predHit, predTaken, predReturn;
  logic lookupSampled;  // fetchValid as seen at the last rising edge

  // Shadow tables
  logic [tagW-1:0] bTag [depth];
  logic [tagW-1:0] rTag [depth];
  logic bValid [depth];
  logic rValid [depth];
  logic [`BTB_ADDR_BITS-1:0] bTarget [depth];
  counterT bCnt [depth];
  counterT rCnt [depth];

  expectT expQ [$];
  int errors = 0;
  int compared = 0;
  int credits = `BTB_QUEUE_DEPTH;
  int minCredits = `BTB_QUEUE_DEPTH;
  integer seed = 32'he42a;
  logic [31:0] r;

  branchPredictor DUT (.*);

  initial begin
    BTBCLK = 1'b0;
    forever #(clkPeriod / 2) BTBCLK = ~BTBCLK;
  end

  function automatic counterT satStep(input counterT c, input logic up);
    if (up) return (c == strongTaken) ? c : counterT'(c + 2'd1);
    return (c == strongNot) ? c : counterT'(c - 2'd1);
  endfunction

  function automatic void modelResolve(input logic [`BTB_ADDR_BITS-1:0] addr,
      input logic isRet, input logic taken, input logic [`BTB_ADDR_BITS-1:0] target);
    int idx;
    logic [tagW-1:0] tag;
    idx = int'(addr[`BTB_INDEX_BITS-1:0]);
    tag = addr[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];
    if (!isRet) begin
      if (bValid[idx] && bTag[idx] == tag) begin
        bCnt[idx] = satStep(bCnt[idx], taken);
        if (taken) bTarget[idx] = target;
      end else if (taken) begin
        bValid[idx] = 1'b1;
        bTag[idx] = tag;
        bTarget[idx] = target;
        bCnt[idx] = weakTaken;  // New entries start weakly taken
      end
    end else if (rValid[idx] && rTag[idx] == tag) begin
      rCnt[idx] = satStep(rCnt[idx], taken);
    end else if (taken) begin
      rValid[idx] = 1'b1;
      rTag[idx] = tag;
      rCnt[idx] = weakTaken;
    end
  endfunction

  function automatic expectT modelLookup(input logic [`BTB_ADDR_BITS-1:0] addr);
    int idx;
    logic bHit, rHit;
    expectT e;
    idx = int'(addr[`BTB_INDEX_BITS-1:0]);
    bHit = bValid[idx] && bTag[idx] == addr[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];
    rHit = rValid[idx] && rTag[idx] == addr[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];
    e.hit = bHit || rHit;
    e.taken = (bHit && bCnt[idx] != strongNot) || (rHit && rCnt[idx] != strongNot);
    e.ret = rHit;
    e.branchHit = bHit;
    e.target = bTarget[idx];
    return e;
  endfunction

  task automatic nextCycle();
    @(posedge BTBCLK);
    #1;
  endtask

  task automatic waitDrain();
    while (credits != `BTB_QUEUE_DEPTH) nextCycle();
  endtask

  task automatic sendResolve(input logic [`BTB_ADDR_BITS-1:0] addr, input logic isRet,
      input logic taken, input logic [`BTB_ADDR_BITS-1:0] target);
    while (credits == 0) nextCycle();  // Hold off until a credit returns
    resolveValid = 1'b1;
    resolveAddr = addr;
    resolveIsReturn = isRet;
    resolveTaken = taken;
    resolveTarget = target;
    credits--;
    if (credits < minCredits) minCredits = credits;
    modelResolve(addr, isRet, taken, target);
    nextCycle();
    resolveValid = 1'b0;
  endtask

  task automatic issueLookup(input logic [`BTB_ADDR_BITS-1:0] addr);
    waitDrain();
    fetchValid = 1'b1;
    fetchAddr = addr;
    expQ.push_back(modelLookup(addr));
    nextCycle();
    fetchValid = 1'b0;
  endtask

  always @(posedge BTBCLK) lookupSampled <= fetchValid;

  always @(negedge BTBCLK) begin
    if (rstN && resolveCredit) begin
      credits++;
      if (credits > `BTB_QUEUE_DEPTH) begin
        errors++;
        $display("More credits returned than records were sent at %0t", $time);
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge BTBCLK) begin : compare
    expectT e;
    if (rstN && predValid !== lookupSampled) begin
      errors++;
      $display("ERROR predValid: expected %h, got %h at %0t",
               lookupSampled, predValid, $time);
    end
    if (rstN && predValid) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("predValid high with no lookup outstanding at %0t", $time);
      end else begin
        e = expQ.pop_front();
        compared++;
        if (predHit !== e.hit) begin
          errors++;
          $display("ERROR predHit: expected %h, got %h at %0t", e.hit, predHit, $time);
        end
        if (predTaken !== e.taken) begin
          errors++;
          $display("ERROR predTaken: expected %h, got %h at %0t", e.taken, predTaken, $time);
        end
        if (predReturn !== e.ret) begin
          errors++;
          $display("ERROR predReturn: expected %h, got %h at %0t", e.ret, predReturn, $time);
        end
        if (e.branchHit && predTarget !== e.target) begin
          errors++;
          $display("ERROR predTarget: expected %h, got %h at %0t",
                   e.target, predTarget, $time);
        end
      end
    end
  end

  initial begin
    #(maxCycles * clkPeriod + 200);
    $display("Watchdog expired, the run did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    fetchValid = 1'b0;
    fetchAddr = '0;
    resolveValid = 1'b0;
    resolveAddr = '0;
    resolveIsReturn = 1'b0;
    resolveTaken = 1'b0;
    resolveTarget = '0;
    for (int i = 0; i < depth; i++) begin
      bValid[i] = 1'b0;
      rValid[i] = 1'b0;
    end
    repeat (8) @(posedge BTBCLK);
    if (predValid !== 1'b0 || resolveCredit !== 1'b0) begin
      errors++;
      $display("Outputs not cleared during reset");
    end
    #1 rstN = 1'b1;
    nextCycle();

    for (int i = 0; i < 20; i++) issueLookup(14'($random(seed)));

    sendResolve(14'h0123, 1'b0, 1'b1, 14'h2a5c);
    issueLookup(14'h0123);
    issueLookup(14'h0123 ^ 14'h0020);  // Same index, other tag

    // Saturate up, down to strongNot, then back
    for (int i = 0; i < 9; i++) begin
      sendResolve(14'h1a47, 1'b0, (i < 3) || (i == 8), 14'h0444);
      issueLookup(14'h1a47);
    end

    sendResolve(14'h0123, 1'b0, 1'b1, 14'h1111);
    issueLookup(14'h0123);
    sendResolve(14'h0c38, 1'b1, 1'b1, 14'h0);
    issueLookup(14'h0c38);
    sendResolve(14'h0123, 1'b1, 1'b1, 14'h0);  // Both tables hit at this index
    issueLookup(14'h0123);

    minCredits = `BTB_QUEUE_DEPTH;
    for (int i = 0; i < 8; i++) begin
      sendResolve(14'h0200 + 14'(i % 6), 1'b0, 1'b1, 14'h3000 + 14'(i));
    end
    if (minCredits != 0) begin
      errors++;
      $display("Burst never used up the credits");
    end
    for (int i = 0; i < 6; i++) issueLookup(14'h0200 + 14'(i));

    for (int i = 0; i < randomOps; i++) begin
      r = $random(seed);
      if (r[11:10] == 2'b00) issueLookup({7'd0, r[6:5], 2'b00, r[2:0]});
      else sendResolve({7'd0, r[6:5], 2'b00, r[2:0]}, r[8], r[9], r[27:14]);
    end

    waitDrain();
    for (int i = 0; i < 10 && expQ.size() != 0; i++) nextCycle();
    if (expQ.size() != 0) begin
      errors++;
      $display("Lookups left without a prediction");
    end
    $display("Done: %0d errors, %0d predictions compared", errors, compared);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
hdl/btbPkg.sv
hdl/btbUpdateIf.sv
hdl/btbUpdateQueue.sv
hdl/btbResolve.sv
hdl/btbLookup.sv
hdl/branchPredictor.sv
bench/branchPredictorTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= branchPredictorTb
FLIST     ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)
